// ==== logic/rv32_exec_macros.svh ====
// Shared constants of the RV32I execute slice
// Opcode values, ALU codes, immediate selects and widths
// Include where an opcode, an ALU code or XLEN is needed
`ifndef RV32_EXEC_MACROS_SVH
`define RV32_EXEC_MACROS_SVH

`define XLEN  32
`define NREGS 32

// Major opcodes, instr[6:0]
`define OP_R   7'b0110011 // Register-register ALU
`define OP_I1  7'b0010011 // Register-immediate ALU
`define OP_I2  7'b0000011 // Loads
`define OP_S   7'b0100011 // Stores
`define OP_BR  7'b1100011 // Conditional branches
`define OP_JR  7'b1100111 // JALR
`define OP_J   7'b1101111 // JAL
`define OP_U   7'b0110111 // LUI
`define OP_UPC 7'b0010111 // AUIPC

// ALU codes, same encoding as alu_ctrl
`define ALU_ADD   4'b0000
`define ALU_SUB   4'b0001
`define ALU_AND   4'b0010
`define ALU_OR    4'b0100
`define ALU_XOR   4'b1000
`define ALU_SRL   4'b1001
`define ALU_SLL   4'b1010
`define ALU_SRA   4'b1100
`define ALU_PASSB 4'b1101

// Immediate format select
`define IMM_I 2'b00
`define IMM_S 2'b01
`define IMM_J 2'b10
`define IMM_U 2'b11

`endif

// ==== logic/rv32_exec_pkg.sv ====
// Types of the execute slice
// Referenced with scoped names by every RTL block and the testbench
`default_nettype none

package rv32_exec_pkg;

    typedef logic [31:0] word_t;     // Data, address or instruction
    typedef logic [4:0]  reg_addr_t; // Register index
    typedef logic [3:0]  alu_op_t;   // ALU code
    typedef logic [1:0]  size_t;     // 00 byte, 01 half, 10 word
    typedef logic [3:0]  strb_t;     // Byte-lane write strobe

    // Writeback source
    // Loads ride on WB_ALU, load data replaces the ALU result
    typedef enum logic [1:0]
    {
        WB_CMP  = 2'b00, // Less-than flag
        WB_ALU  = 2'b01, // ALU result or load data
        WB_LINK = 2'b10  // pc + 4
    } wb_sel_t;

endpackage

`default_nettype wire

// ==== logic/control_unit.sv ====
// RV32I instruction decoder
// Produces the ALU code, access size, signed flag and writeback source,
// plus operand selects and the memory and writeback enables.
// Unknown encodings raise illegal, and every enable is gated by instr_valid.
`timescale 1ns/1ps
`default_nettype none
`include "rv32_exec_macros.svh"

module control_unit
(
    input  wire  rv32_exec_pkg::word_t instr,
    input  wire                        instr_valid,
    output rv32_exec_pkg::alu_op_t     alu_ctrl,
    output rv32_exec_pkg::size_t       whb,
    output logic                       su,
    output rv32_exec_pkg::wb_sel_t     wos,
    output logic [1:0]                 imm_sel,
    output logic                       a_pc,     // Operand A is pc
    output logic                       b_imm,    // Operand B is the immediate
    output logic                       rd_we,
    output logic                       mem_re,
    output logic                       mem_we,
    output logic                       illegal
);

    logic [6:0] opcode;
    logic [2:0] func3;
    logic [6:0] func7;
    logic       f7_zero, f7_alt;
    logic       alt;                          // SUB or SRA variant
    rv32_exec_pkg::alu_op_t arith_op;
    logic       writes_rd, is_load, is_store, bad;

    assign opcode  = instr[6:0];
    assign func3   = instr[14:12];
    assign func7   = instr[31:25];
    assign f7_zero = (func7 == 7'b0000000);
    assign f7_alt  = (func7 == 7'b0100000);
    // ADDI must never turn into SUB, so imm bit 30 counts for shifts only
    assign alt     = instr[30] && (opcode == `OP_R || func3 == 3'b101);

    // ALU code shared by the R and I1 classes
    always_comb
    begin
        case (func3)
            3'b000:         arith_op = alt ? `ALU_SUB : `ALU_ADD;
            3'b001:         arith_op = `ALU_SLL;
            3'b010, 3'b011: arith_op = `ALU_SUB; // SLT/SLTU compare
            3'b100:         arith_op = `ALU_XOR;
            3'b101:         arith_op = alt ? `ALU_SRA : `ALU_SRL;
            3'b110:         arith_op = `ALU_OR;
            default:        arith_op = `ALU_AND;
        endcase
    end

    always_comb
    begin
        // Control group defaults: ADD, word, signed, ALU writeback
        alu_ctrl  = `ALU_ADD;
        whb       = 2'b10;
        su        = 1'b1;
        wos       = rv32_exec_pkg::WB_ALU;
        imm_sel   = `IMM_I;
        a_pc      = 1'b0;
        b_imm     = 1'b0;
        writes_rd = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        bad       = 1'b0;
        case (opcode)
            `OP_R, `OP_I1:
            begin
                writes_rd = 1'b1;
                alu_ctrl  = arith_op;
                b_imm     = (opcode == `OP_I1);
                su        = (func3 != 3'b011);          // SLTU/SLTIU unsigned
                if (func3[2:1] == 2'b01)
                    wos = rv32_exec_pkg::WB_CMP;
                if (opcode == `OP_R)                    // func7 checked per op
                    bad = !(f7_zero || (f7_alt && (func3 == 3'b000 || func3 == 3'b101)));
                else if (func3 == 3'b001)
                    bad = !f7_zero;                     // SLLI
                else if (func3 == 3'b101)
                    bad = !(f7_zero || f7_alt);         // SRLI, SRAI
            end
            `OP_I2:
            begin
                writes_rd = 1'b1;
                is_load   = 1'b1;
                b_imm     = 1'b1;
                whb       = func3[1:0];
                su        = !func3[2];                  // LBU, LHU zero-extend
                bad       = (func3[1:0] == 2'b11) || (func3[2] && func3[1]);
            end
            `OP_S:
            begin
                is_store = 1'b1;
                b_imm    = 1'b1;
                imm_sel  = `IMM_S;
                whb      = func3[1:0];
                bad      = func3[2] || (func3[1:0] == 2'b11);
            end
            `OP_BR:
            begin
                alu_ctrl = `ALU_SUB;                    // Compare only, no writeback
                bad      = (func3[2:1] == 2'b01);
            end
            `OP_JR:
            begin
                writes_rd = 1'b1;
                wos       = rv32_exec_pkg::WB_LINK;
                b_imm     = 1'b1;                       // rs1 + imm, target unused
                bad       = (func3 != 3'b000);
            end
            `OP_J:
            begin
                writes_rd = 1'b1;
                wos       = rv32_exec_pkg::WB_LINK;
                a_pc      = 1'b1;
                b_imm     = 1'b1;
                imm_sel   = `IMM_J;
            end
            `OP_U, `OP_UPC:
            begin
                writes_rd = 1'b1;
                b_imm     = 1'b1;
                imm_sel   = `IMM_U;
                a_pc      = (opcode == `OP_UPC);        // AUIPC adds pc
                if (opcode == `OP_U)
                    alu_ctrl = `ALU_PASSB;
            end
            default: bad = 1'b1;                        // FENCE, SYSTEM and the rest
        endcase
    end

    // Enables only for a valid, legal instruction
    assign illegal = instr_valid && bad;
    assign rd_we   = instr_valid && !bad && writes_rd;
    assign mem_re  = instr_valid && !bad && is_load;
    assign mem_we  = instr_valid && !bad && is_store;

endmodule

`default_nettype wire

// ==== logic/operand_gen.sv ====
// Operand generator
// Extracts the I, S, J or U immediate and selects the two ALU operands
`timescale 1ns/1ps
`default_nettype none
`include "rv32_exec_macros.svh"

module operand_gen
(
    input  wire rv32_exec_pkg::word_t instr,
    input  wire rv32_exec_pkg::word_t pc,
    input  wire rv32_exec_pkg::word_t rs1_data,
    input  wire rv32_exec_pkg::word_t rs2_data,
    input  wire [1:0]                 imm_sel,
    input  wire                       a_pc,
    input  wire                       b_imm,
    output rv32_exec_pkg::word_t      op_a,
    output rv32_exec_pkg::word_t      op_b
);

    rv32_exec_pkg::word_t imm;

    always_comb
    begin
        case (imm_sel)
            `IMM_S:  imm = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            `IMM_J:  imm = {{(`XLEN-20){instr[31]}}, instr[19:12], instr[20],
                            instr[30:21], 1'b0};   // JAL offset, bit 0 zero
            `IMM_U:  imm = {instr[31:12], 12'b0};  // Upper 20 bits
            default: imm = {{(`XLEN-12){instr[31]}}, instr[31:20]};
        endcase
    end

    assign op_a = a_pc  ? pc  : rs1_data; // JAL, AUIPC
    assign op_b = b_imm ? imm : rs2_data;

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
// Integer ALU of the execute slice
// Add, subtract, logic ops and shifts; less-than flags from the shared subtract
`timescale 1ns/1ps
`default_nettype none
`include "rv32_exec_macros.svh"

module alu
(
    input  wire rv32_exec_pkg::word_t   op_a,
    input  wire rv32_exec_pkg::word_t   op_b,
    input  wire rv32_exec_pkg::alu_op_t alu_ctrl,
    output rv32_exec_pkg::word_t        result,
    output logic                        lt_s,
    output logic                        lt_u
);

    logic [`XLEN:0] diff;  // Extra bit holds the borrow
    logic [4:0]     shamt;

    assign diff  = {1'b0, op_a} - {1'b0, op_b};
    assign shamt = op_b[4:0];

    // Borrow gives unsigned less-than
    assign lt_u = diff[`XLEN];
    // Signs differ means op_a's sign decides, else the difference's sign
    assign lt_s = (op_a[`XLEN-1] != op_b[`XLEN-1]) ? op_a[`XLEN-1] : diff[`XLEN-1];

    always_comb
    begin
        case (alu_ctrl)
            `ALU_ADD:   result = op_a + op_b;
            `ALU_SUB:   result = diff[`XLEN-1:0];
            `ALU_AND:   result = op_a & op_b;
            `ALU_OR:    result = op_a | op_b;
            `ALU_XOR:   result = op_a ^ op_b;
            `ALU_SRL:   result = op_a >> shamt;
            `ALU_SLL:   result = op_a << shamt;
            `ALU_SRA:   result = $signed(op_a) >>> shamt;
            `ALU_PASSB: result = op_b;              // LUI
            default:    result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
// Integer register file, 32 entries of 32 bits
// Two combinational read ports, one write port taken at the rising edge.
// x0 always reads zero; reset clears every entry.
`timescale 1ns/1ps
`default_nettype none

module reg_file
(
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire rv32_exec_pkg::reg_addr_t  rs1_addr,
    input  wire rv32_exec_pkg::reg_addr_t  rs2_addr,
    input  wire rv32_exec_pkg::reg_addr_t  wb_addr,
    input  wire                            wb_en,
    input  wire rv32_exec_pkg::word_t      wb_data,
    output rv32_exec_pkg::word_t           rs1_data,
    output rv32_exec_pkg::word_t           rs2_data
);

    rv32_exec_pkg::word_t regs [0:31];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wb_en)
            regs[wb_addr] <= wb_data;  // Visible to reads next cycle
    end

    // Index 0 forced to zero whatever the array holds
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== logic/load_store_unit.sv ====
// Load/store lane logic
// Stores: replicate the byte or half over all lanes, strobe the addressed lanes.
// Loads: pick the addressed byte or half and extend by su.
// Misaligned accesses use the low address bits as they are, no trap.
`timescale 1ns/1ps
`default_nettype none

module load_store_unit
(
    input  wire rv32_exec_pkg::word_t  addr,
    input  wire rv32_exec_pkg::size_t  whb,
    input  wire                        su,
    input  wire rv32_exec_pkg::word_t  store_data,
    input  wire                        mem_we,
    input  wire rv32_exec_pkg::word_t  mem_rdata,
    output rv32_exec_pkg::strb_t       mem_wstrb,
    output rv32_exec_pkg::word_t       mem_wdata,
    output rv32_exec_pkg::word_t       load_data
);

    logic [1:0]           ofs;
    rv32_exec_pkg::strb_t strb;
    rv32_exec_pkg::word_t shifted;   // Addressed byte moved to lane 0
    logic [15:0]          half;

    assign ofs     = addr[1:0];
    assign shifted = mem_rdata >> {ofs, 3'b000};
    assign half    = ofs[1] ? mem_rdata[31:16] : mem_rdata[15:0];

    always_comb
    begin
        case (whb)
            2'b00:
            begin
                mem_wdata = {4{store_data[7:0]}};
                strb      = 4'b0001 << ofs;
                load_data = {{24{su & shifted[7]}}, shifted[7:0]};
            end
            2'b01:
            begin
                mem_wdata = {2{store_data[15:0]}};
                strb      = ofs[1] ? 4'b1100 : 4'b0011; // Upper or lower half
                load_data = {{16{su & half[15]}}, half};
            end
            default:
            begin
                mem_wdata = store_data;
                strb      = 4'b1111;
                load_data = mem_rdata;
            end
        endcase
    end

    assign mem_wstrb = mem_we ? strb : '0;  // No lanes outside a store

endmodule

`default_nettype wire

// ==== logic/rv32_exec.sv ====
// Execute slice of a single-issue RV32I core
// One instruction per cycle: decode, register read, ALU, memory access and
// the writeback value all settle in the cycle that instr_valid is high.
// The register file takes the writeback at the next rising edge.
`timescale 1ns/1ps
`default_nettype none

module rv32_exec
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire rv32_exec_pkg::word_t   instr,
    input  wire rv32_exec_pkg::word_t   pc,
    input  wire                         instr_valid,
    input  wire rv32_exec_pkg::word_t   mem_rdata,
    output rv32_exec_pkg::word_t        mem_addr,
    output rv32_exec_pkg::word_t        mem_wdata,
    output rv32_exec_pkg::strb_t        mem_wstrb,
    output logic                        mem_we,
    output logic                        mem_re,
    output logic                        wb_en,
    output rv32_exec_pkg::reg_addr_t    wb_addr,
    output rv32_exec_pkg::word_t        wb_data,
    output logic                        illegal
);

    rv32_exec_pkg::alu_op_t  alu_ctrl;
    rv32_exec_pkg::size_t    whb;
    rv32_exec_pkg::wb_sel_t  wos;
    logic                    su, a_pc, b_imm, rd_we;
    logic [1:0]              imm_sel;
    rv32_exec_pkg::word_t    rs1_data, rs2_data, op_a, op_b;
    rv32_exec_pkg::word_t    alu_result, load_data;
    logic                    lt_s, lt_u;

    assign wb_addr  = instr[11:7];             // rd
    assign wb_en    = rd_we && (wb_addr != '0); // x0 never written
    assign mem_addr = alu_result;              // rs1 + imm for loads and stores

    control_unit control_unit_inst
    (
        .instr       (instr),
        .instr_valid (instr_valid),
        .alu_ctrl    (alu_ctrl),
        .whb         (whb),
        .su          (su),
        .wos         (wos),
        .imm_sel     (imm_sel),
        .a_pc        (a_pc),
        .b_imm       (b_imm),
        .rd_we       (rd_we),
        .mem_re      (mem_re),
        .mem_we      (mem_we),
        .illegal     (illegal)
    );

    reg_file reg_file_inst
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (instr[19:15]),
        .rs2_addr (instr[24:20]),
        .wb_addr  (wb_addr),
        .wb_en    (wb_en),
        .wb_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    operand_gen operand_gen_inst
    (
        .instr    (instr),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm_sel  (imm_sel),
        .a_pc     (a_pc),
        .b_imm    (b_imm),
        .op_a     (op_a),
        .op_b     (op_b)
    );

    alu alu_inst
    (
        .op_a     (op_a),
        .op_b     (op_b),
        .alu_ctrl (alu_ctrl),
        .result   (alu_result),
        .lt_s     (lt_s),
        .lt_u     (lt_u)
    );

    load_store_unit load_store_unit_inst
    (
        .addr       (alu_result),
        .whb        (whb),
        .su         (su),
        .store_data (rs2_data),
        .mem_we     (mem_we),
        .mem_rdata  (mem_rdata),
        .mem_wstrb  (mem_wstrb),
        .mem_wdata  (mem_wdata),
        .load_data  (load_data)
    );

    // Writeback select
    always_comb
    begin
        case (wos)
            rv32_exec_pkg::WB_CMP:  wb_data = {31'd0, su ? lt_s : lt_u}; // SLT(I)(U)
            rv32_exec_pkg::WB_LINK: wb_data = pc + 32'd4;                // JAL, JALR
            default:                wb_data = mem_re ? load_data : alu_result;
        endcase
    end

endmodule

`default_nettype wire

// ==== testbench/rv32_exec_props.sv ====
// Bound assertions for the execute slice
// Attached to every rv32_exec with bind from the testbench top
// Watches the memory and writeback enables at each rising edge
`timescale 1ns/1ps
`default_nettype none

module rv32_exec_props
(
    input wire                           clk,
    input wire                           instr_valid,
    input wire                           mem_we,
    input wire                           mem_re,
    input wire                           wb_en,
    input wire                           illegal,
    input wire rv32_exec_pkg::reg_addr_t wb_addr
);

    // Load and store never in the same cycle
    mem_excl: assert property (@(posedge clk) !(mem_we && mem_re))
        else $error("mem_we and mem_re high in the same cycle");

    // Idle or in reset, every enable quiet
    idle_quiet: assert property (@(posedge clk)
        !instr_valid |-> !(wb_en || mem_we || mem_re || illegal))
        else $error("enable high while instr_valid is low");

    // x0 is never a writeback target
    no_x0_write: assert property (@(posedge clk) wb_en |-> (wb_addr != 5'd0))
        else $error("wb_en high with wb_addr zero");

endmodule

`default_nettype wire

// ==== testbench/rv32_exec_checker.sv ====
// Output checker of the execute slice testbench
// Samples the DUT outputs at the falling edge, mid-cycle, and compares them
// with the expected row that the testbench presents; counts the errors
`timescale 1ns/1ps
`default_nettype none

module rv32_exec_checker
(
    input  wire                           clk,
    input  wire                           check_en,
    input  wire                           exp_wb_en,
    input  wire rv32_exec_pkg::reg_addr_t exp_wb_addr,
    input  wire rv32_exec_pkg::word_t     exp_wb_data,
    input  wire                           exp_mem_we,
    input  wire                           exp_mem_re,
    input  wire rv32_exec_pkg::word_t     exp_mem_addr,
    input  wire rv32_exec_pkg::word_t     exp_mem_wdata,
    input  wire rv32_exec_pkg::strb_t     exp_mem_wstrb,
    input  wire                           exp_illegal,
    input  wire                           wb_en,
    input  wire rv32_exec_pkg::reg_addr_t wb_addr,
    input  wire rv32_exec_pkg::word_t     wb_data,
    input  wire                           mem_we,
    input  wire                           mem_re,
    input  wire rv32_exec_pkg::word_t     mem_addr,
    input  wire rv32_exec_pkg::word_t     mem_wdata,
    input  wire rv32_exec_pkg::strb_t     mem_wstrb,
    input  wire                           illegal,
    output int                            errors
);

    initial errors = 0;

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
        begin
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
            errors++;
        end
    endtask

    always @(negedge clk)
    begin
        if (check_en)
        begin
            compare("wb_en", 32'(exp_wb_en), 32'(wb_en));
            compare("mem_we", 32'(exp_mem_we), 32'(mem_we));
            compare("mem_re", 32'(exp_mem_re), 32'(mem_re));
            compare("illegal", 32'(exp_illegal), 32'(illegal));
            compare("mem_wstrb", 32'(exp_mem_wstrb), 32'(mem_wstrb)); // Zero outside stores
            if (exp_wb_en)
            begin
                compare("wb_addr", 32'(exp_wb_addr), 32'(wb_addr));
                compare("wb_data", exp_wb_data, wb_data);
            end
            if (exp_mem_we || exp_mem_re)
                compare("mem_addr", exp_mem_addr, mem_addr);
            if (exp_mem_we)
                compare("mem_wdata", exp_mem_wdata, mem_wdata); // Replicated lanes
        end
    end

endmodule

`default_nettype wire

// ==== testbench/rv32_exec_tb.sv ====
// Testbench top for the RV32I execute slice
// Builds a short program in a table with the expected outputs of each row,
// applies one row per cycle and lets the checker compare the DUT outputs.
// Holds a 64-word memory model with combinational read, and a watchdog.
`timescale 1ns/1ps
`default_nettype none
`include "rv32_exec_macros.svh"

module rv32_exec_tb;

    localparam int MAX_ROWS = 64;

    logic                      clk, rst_n, instr_valid;
    rv32_exec_pkg::word_t      instr, pc, mem_rdata, mem_addr, mem_wdata, wb_data;
    rv32_exec_pkg::strb_t      mem_wstrb;
    rv32_exec_pkg::reg_addr_t  wb_addr;
    logic                      mem_we, mem_re, wb_en, illegal;

    rv32_exec_pkg::word_t      mem [0:63];         // Data memory model
    rv32_exec_pkg::word_t      r [0:31];           // Expected register contents
    rv32_exec_pkg::word_t      t_instr [0:MAX_ROWS-1];
    rv32_exec_pkg::word_t      t_pc [0:MAX_ROWS-1];
    logic                      t_valid [0:MAX_ROWS-1];
    logic                      e_wb_en [0:MAX_ROWS-1];
    rv32_exec_pkg::reg_addr_t  e_wb_addr [0:MAX_ROWS-1];
    rv32_exec_pkg::word_t      e_wb_data [0:MAX_ROWS-1];
    logic                      e_we [0:MAX_ROWS-1];
    logic                      e_re [0:MAX_ROWS-1];
    rv32_exec_pkg::word_t      e_addr [0:MAX_ROWS-1];
    rv32_exec_pkg::word_t      e_wdata [0:MAX_ROWS-1];
    rv32_exec_pkg::strb_t      e_strb [0:MAX_ROWS-1];
    logic                      e_ill [0:MAX_ROWS-1];
    int                        n_rows, cur, errors;
    integer                    seed;
    bit                        table_done, chk_on;

    always #10 clk = ~clk;  // 20 ns period

    // Memory model: combinational read, lane writes at the edge
    assign mem_rdata = mem[mem_addr[7:2]];
    always @(posedge clk)
    begin
        if (mem_we)
        begin
            for (int k = 0; k < 4; k++)
                if (mem_wstrb[k])
                    mem[mem_addr[7:2]][8*k +: 8] = mem_wdata[8*k +: 8];
        end
    end

    rv32_exec rv32_exec_inst
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .pc          (pc),
        .instr_valid (instr_valid),
        .mem_rdata   (mem_rdata),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_we      (mem_we),
        .mem_re      (mem_re),
        .wb_en       (wb_en),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .illegal     (illegal)
    );

    rv32_exec_checker rv32_exec_checker_inst
    (
        .clk           (clk),
        .check_en      (chk_on),
        .exp_wb_en     (e_wb_en[cur]),
        .exp_wb_addr   (e_wb_addr[cur]),
        .exp_wb_data   (e_wb_data[cur]),
        .exp_mem_we    (e_we[cur]),
        .exp_mem_re    (e_re[cur]),
        .exp_mem_addr  (e_addr[cur]),
        .exp_mem_wdata (e_wdata[cur]),
        .exp_mem_wstrb (e_strb[cur]),
        .exp_illegal   (e_ill[cur]),
        .wb_en         (wb_en),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .mem_we        (mem_we),
        .mem_re        (mem_re),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_wstrb     (mem_wstrb),
        .illegal       (illegal),
        .errors        (errors)
    );

    bind rv32_exec rv32_exec_props rv32_exec_props_inst
    (
        .clk         (clk),
        .instr_valid (instr_valid),
        .mem_we      (mem_we),
        .mem_re      (mem_re),
        .wb_en       (wb_en),
        .illegal     (illegal),
        .wb_addr     (wb_addr)
    );

    // Instruction encoders, RV32I field order
    function automatic rv32_exec_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OP_R};
    endfunction

    function automatic rv32_exec_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv32_exec_pkg::word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `OP_S};
    endfunction

    function automatic rv32_exec_pkg::word_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
        input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic rv32_exec_pkg::word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_J};
    endfunction

    function automatic rv32_exec_pkg::word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic rv32_exec_pkg::word_t row_pc();
        return 32'h100 + 32'(n_rows) * 4;  // Program starts at 0x100
    endfunction

    // Opens a row with every expectation cleared
    task automatic new_row(input rv32_exec_pkg::word_t ins, input logic valid);
        t_instr[n_rows] = ins;
        t_pc[n_rows] = row_pc();
        t_valid[n_rows] = valid;
        e_wb_en[n_rows] = 1'b0;
        e_wb_addr[n_rows] = ins[11:7];
        e_wb_data[n_rows] = '0;
        e_we[n_rows] = 1'b0;
        e_re[n_rows] = 1'b0;
        e_addr[n_rows] = '0;
        e_wdata[n_rows] = '0;
        e_strb[n_rows] = '0;
        e_ill[n_rows] = 1'b0;
    endtask

    // rd of x0 expects no writeback
    task automatic set_wb(input rv32_exec_pkg::word_t data);
        if (t_instr[n_rows][11:7] != 5'd0)
        begin
            e_wb_en[n_rows] = 1'b1;
            e_wb_data[n_rows] = data;
            r[t_instr[n_rows][11:7]] = data;
        end
    endtask

    task automatic wr(input rv32_exec_pkg::word_t ins, input rv32_exec_pkg::word_t data);
        new_row(ins, 1'b1);
        set_wb(data);
        n_rows++;
    endtask

    task automatic ld(input rv32_exec_pkg::word_t ins, input rv32_exec_pkg::word_t addr,
        input rv32_exec_pkg::word_t data);
        new_row(ins, 1'b1);
        e_re[n_rows] = 1'b1;
        e_addr[n_rows] = addr;
        set_wb(data);
        n_rows++;
    endtask

    task automatic st(input rv32_exec_pkg::word_t ins, input rv32_exec_pkg::word_t addr,
        input rv32_exec_pkg::word_t wdata, input rv32_exec_pkg::strb_t strb);
        new_row(ins, 1'b1);
        e_we[n_rows] = 1'b1;
        e_addr[n_rows] = addr;
        e_wdata[n_rows] = wdata;
        e_strb[n_rows] = strb;
        n_rows++;
    endtask

    task automatic quiet(input rv32_exec_pkg::word_t ins, input logic valid, input logic ill);
        new_row(ins, valid);
        e_ill[n_rows] = ill;
        n_rows++;
    endtask

    task automatic build_program();
        logic [11:0] imm;
        seed = 18;
        n_rows = 0;
        for (int i = 0; i < 32; i++)
            r[i] = '0;
        // Setup, random ADDI immediates
        imm = 12'($random(seed));
        wr(enc_i(imm, 5'd0, 3'b000, 5'd1, `OP_I1), sext12(imm));
        imm = 12'($random(seed));
        wr(enc_i(imm, 5'd0, 3'b000, 5'd2, `OP_I1), sext12(imm));
        imm = 12'($random(seed));
        wr(enc_i(imm, 5'd1, 3'b000, 5'd3, `OP_I1), r[1] + sext12(imm));
        wr(enc_u(20'h80000, 5'd5, `OP_U), 32'h8000_0000);          // LUI
        wr(enc_i(12'd1, 5'd0, 3'b000, 5'd6, `OP_I1), 32'd1);
        wr(enc_u(20'hA1B2C, 5'd8, `OP_U), 32'hA1B2_C000);
        wr(enc_i(12'h3D4, 5'd8, 3'b000, 5'd8, `OP_I1), r[8] + 32'h3D4); // Reads last row
        wr(enc_i(12'h040, 5'd0, 3'b000, 5'd7, `OP_I1), 32'h40);    // Store base
        // Register and immediate ALU ops
        wr(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd9), r[1] + r[2]);
        wr(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd10), r[1] - r[2]);
        wr(enc_r(7'h00, 5'd3, 5'd8, 3'b111, 5'd11), r[8] & r[3]);
        wr(enc_r(7'h00, 5'd8, 5'd1, 3'b110, 5'd12), r[1] | r[8]);
        wr(enc_r(7'h00, 5'd3, 5'd8, 3'b100, 5'd13), r[8] ^ r[3]);
        wr(enc_r(7'h00, 5'd2, 5'd8, 3'b001, 5'd14), r[8] << r[2][4:0]);
        wr(enc_r(7'h00, 5'd2, 5'd8, 3'b101, 5'd15), r[8] >> r[2][4:0]);
        wr(enc_r(7'h20, 5'd2, 5'd8, 3'b101, 5'd16), 32'($signed(r[8]) >>> r[2][4:0]));
        wr(enc_i(12'd7, 5'd8, 3'b001, 5'd17, `OP_I1), r[8] << 7);
        wr(enc_i(12'd9, 5'd8, 3'b101, 5'd18, `OP_I1), r[8] >> 9);
        wr(enc_i(12'h409, 5'd8, 3'b101, 5'd19, `OP_I1), 32'($signed(r[8]) >>> 9)); // SRAI
        // Compares where signed and unsigned disagree
        wr(enc_r(7'h00, 5'd6, 5'd5, 3'b010, 5'd20), {31'd0, $signed(r[5]) < $signed(r[6])});
        wr(enc_r(7'h00, 5'd6, 5'd5, 3'b011, 5'd21), {31'd0, r[5] < r[6]});
        wr(enc_i(12'd1, 5'd5, 3'b010, 5'd22, `OP_I1), {31'd0, $signed(r[5]) < 32'sd1});
        wr(enc_i(12'd1, 5'd5, 3'b011, 5'd23, `OP_I1), {31'd0, r[5] < 32'd1});
        wr(enc_i(12'hFFF, 5'd6, 3'b011, 5'd24, `OP_I1), {31'd0, r[6] < sext12(12'hFFF)});
        wr(enc_i(12'hFFF, 5'd6, 3'b010, 5'd25, `OP_I1),
           {31'd0, $signed(r[6]) < $signed(sext12(12'hFFF))});
        // Stores then loads back through the memory model
        st(enc_s(12'd0, 5'd8, 5'd7, 3'b010), r[7], r[8], 4'b1111);
        st(enc_s(12'd5, 5'd8, 5'd7, 3'b000), r[7] + 5, {4{r[8][7:0]}}, 4'b0010);
        st(enc_s(12'd10, 5'd8, 5'd7, 3'b001), r[7] + 10, {2{r[8][15:0]}}, 4'b1100);
        ld(enc_i(12'd0, 5'd7, 3'b010, 5'd26, `OP_I2), r[7], r[8]);
        ld(enc_i(12'd2, 5'd7, 3'b001, 5'd27, `OP_I2), r[7] + 2, {{16{r[8][31]}}, r[8][31:16]});
        ld(enc_i(12'd2, 5'd7, 3'b101, 5'd28, `OP_I2), r[7] + 2, {16'd0, r[8][31:16]});
        ld(enc_i(12'd5, 5'd7, 3'b000, 5'd29, `OP_I2), r[7] + 5, {{24{r[8][7]}}, r[8][7:0]});
        ld(enc_i(12'd5, 5'd7, 3'b100, 5'd30, `OP_I2), r[7] + 5, {24'd0, r[8][7:0]});
        ld(enc_i(12'd10, 5'd7, 3'b001, 5'd31, `OP_I2), r[7] + 10,
           {{16{r[8][15]}}, r[8][15:0]});
        // Jumps, AUIPC and a branch
        wr(enc_j(21'd16, 5'd1), row_pc() + 4);
        wr(enc_i(12'd0, 5'd7, 3'b000, 5'd2, `OP_JR), row_pc() + 4);
        wr(enc_u(20'h12345, 5'd3, `OP_UPC), row_pc() + 32'h1234_5000);
        quiet({7'd0, 5'd2, 5'd1, 3'b000, 5'd8, `OP_BR}, 1'b1, 1'b0); // BEQ x1, x2
        // x0 stays zero
        wr(enc_i(12'd5, 5'd6, 3'b000, 5'd0, `OP_I1), 32'd0);
        wr(enc_r(7'h00, 5'd6, 5'd0, 3'b000, 5'd4), r[0] + r[6]);
        // Illegal encodings and an idle cycle
        quiet(32'h0000_0073, 1'b1, 1'b1);                          // ECALL
        quiet(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd9), 1'b1, 1'b1); // MUL
        quiet(32'hFFFF_FFFF, 1'b1, 1'b1);
        quiet(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd9), 1'b0, 1'b0); // Not valid
        wr(enc_r(7'h00, 5'd0, 5'd9, 3'b000, 5'd4), r[9]);          // x9 untouched
    endtask

    initial
    begin
        clk = 1'b0;
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        pc = '0;
        chk_on = 1'b0;
        cur = 0;
        for (int i = 0; i < 64; i++)
            mem[i] = (32'(i) * 32'h0103_0507) ^ 32'h5A5A_A5A5;
        build_program();
        table_done = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < n_rows; i++)
        begin
            @(posedge clk);
            #1;                       // Drive just after the edge
            cur = i;
            instr = t_instr[i];
            pc = t_pc[i];
            instr_valid = t_valid[i];
            chk_on = 1'b1;
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        chk_on = 1'b0;
        @(posedge clk);
        $display("Checks done: %0d rows applied, %0d errors", n_rows, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    // Watchdog, sized from the program length
    initial
    begin
        wait (table_done);
        #((n_rows + 16 + 10) * 20);
        $display("Timeout: the run did not finish within %0d cycles", n_rows + 26);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv32_exec.f ====
+incdir+logic
logic/rv32_exec_pkg.sv
logic/control_unit.sv
logic/operand_gen.sv
logic/alu.sv
logic/reg_file.sv
logic/load_store_unit.sv
logic/rv32_exec.sv
testbench/rv32_exec_props.sv
testbench/rv32_exec_checker.sv
testbench/rv32_exec_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and pass only on the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rv32_exec.f --top-module rv32_exec_tb -o rv32_exec_sim

result=$(./obj_dir/rv32_exec_sim 2>&1) || true
echo "$result"
echo "$result" | grep -q "Testbench passed"
